// File: common/robPkg.sv
`default_nettype none

package robPkg;

  // one slot of the reorder buffer always stays empty
  parameter int robDepthDefault = 16;

  // drain controller states
  typedef enum logic {
    idle,
    drain
  } robStateT;

endpackage

`default_nettype wire

// File: common/renamePkg.sv
`default_nettype none

package renamePkg;

  // register file sizes
  parameter int numArchRegs = 32;
  parameter int numPhysRegs = 64;

  // tags not held by the architectural map at reset
  parameter int freeDepth = numPhysRegs - numArchRegs;

  // architectural register index
  typedef logic [$clog2(numArchRegs)-1:0] archRegT;

  // physical register tag
  typedef logic [$clog2(numPhysRegs)-1:0] physRegT;

endpackage

`default_nettype wire

// File: rtl/ringPointers.sv
`default_nettype none
`timescale 1ns/1ns

module ringPointers #(
  parameter int robDepth = robPkg::robDepthDefault,
  localparam int idxW = $clog2(robDepth)
) (
  input  wire logic            clock,
  input  wire logic            reset,
  input  wire logic            advanceHead,
  input  wire logic            advanceTail,
  input  wire logic            loadTail,
  input  wire logic [idxW-1:0] loadValue,
  output logic      [idxW-1:0] head,
  output logic      [idxW-1:0] tail,
  output logic                 full,
  output logic                 empty
);

  logic [idxW-1:0] tailPlusOne;

  // one slot kept free so full and empty differ
  assign tailPlusOne = tail + 1'b1;
  assign full = (tailPlusOne == head);
  assign empty = (head == tail);

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (advanceHead) begin
        head <= head + 1'b1;
      end
      // rollback load wins over a dispatch
      if (loadTail) begin
        tail <= loadValue;
      end else if (advanceTail) begin
        tail <= tailPlusOne;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/rollbackControl.sv
`default_nettype none
`timescale 1ns/1ns

module rollbackControl (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic rollbackTaken,
  input  wire logic bufferEmpty,
  output logic      draining,
  output logic      recover
);

  robPkg::robStateT state;
  robPkg::robStateT nextState;

  always_comb begin
    nextState = state;
    recover = 1'b0;
    case (state)
      robPkg::idle: begin
        if (rollbackTaken) begin
          nextState = robPkg::drain;
        end
      end
      robPkg::drain: begin
        // everything older than the branch has retired
        if (bufferEmpty) begin
          nextState = robPkg::idle;
          recover = 1'b1;
        end
      end
    endcase
  end

  assign draining = (state == robPkg::drain);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= robPkg::idle;
    end else begin
      state <= nextState;
    end
  end

endmodule

`default_nettype wire

// File: rob/robEntries.sv
`default_nettype none
`timescale 1ns/1ns

module robEntries #(
  parameter int robDepth = robPkg::robDepthDefault,
  localparam int idxW = $clog2(robDepth)
) (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               write,
  input  wire logic [idxW-1:0]    writeIdx,
  input  wire renamePkg::archRegT writeArch,
  input  wire renamePkg::physRegT writePhys,
  input  wire renamePkg::physRegT writeOldPhys,
  input  wire logic               writeHalt,
  input  wire logic               markComplete,
  input  wire logic [idxW-1:0]    completeIdx,
  input  wire logic               releaseHead,
  input  wire logic [idxW-1:0]    headIdx,
  input  wire logic               flush,
  input  wire logic [idxW-1:0]    flushIdx,
  input  wire logic [idxW-1:0]    tailIdx,
  output logic                    headValid,
  output logic                    headComplete,
  output logic                    headHalt,
  output renamePkg::archRegT      headArch,
  output renamePkg::physRegT      headPhys,
  output renamePkg::physRegT      headOldPhys,
  output logic                    flushTargetValid
);

  logic               valid   [robDepth];
  logic               done    [robDepth];
  logic               haltBit [robDepth];
  renamePkg::archRegT arch    [robDepth];
  renamePkg::physRegT phys    [robDepth];
  renamePkg::physRegT oldPhys [robDepth];
  logic [robDepth-1:0] flushMask;

  assign headValid = valid[headIdx];
  assign headComplete = done[headIdx];
  assign headHalt = haltBit[headIdx];
  assign headArch = arch[headIdx];
  assign headPhys = phys[headIdx];
  assign headOldPhys = oldPhys[headIdx];
  assign flushTargetValid = valid[flushIdx];

  // entries strictly younger than the branch, up to the tail
  always_comb begin
    for (int i = 0; i < robDepth; i++) begin
      if (flushIdx < tailIdx) begin
        flushMask[i] = (idxW'(i) > flushIdx) && (idxW'(i) < tailIdx);
      end else begin
        // range wraps past the top of the buffer
        flushMask[i] = (idxW'(i) > flushIdx) || (idxW'(i) < tailIdx);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < robDepth; i++) begin
        valid[i] <= 1'b0;
        done[i] <= 1'b0;
      end
    end else begin
      if (write) begin
        valid[writeIdx] <= 1'b1;
        done[writeIdx] <= 1'b0;
      end
      // late completion of a flushed entry is dropped
      if (markComplete && valid[completeIdx]) begin
        done[completeIdx] <= 1'b1;
      end
      if (releaseHead) begin
        valid[headIdx] <= 1'b0;
      end
      if (flush) begin
        for (int i = 0; i < robDepth; i++) begin
          if (flushMask[i]) begin
            valid[i] <= 1'b0;
          end
        end
      end
    end
  end

  // payload fields
  always_ff @(posedge clock) begin
    if (write) begin
      arch[writeIdx] <= writeArch;
      phys[writeIdx] <= writePhys;
      oldPhys[writeIdx] <= writeOldPhys;
      haltBit[writeIdx] <= writeHalt;
    end
  end

endmodule

`default_nettype wire

// File: rob/reorderBuffer.sv
`default_nettype none
`timescale 1ns/1ns

module reorderBuffer #(
  parameter int robDepth = robPkg::robDepthDefault,
  localparam int idxW = $clog2(robDepth)
) (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               dispatch,
  input  wire logic               dispatchHalt,
  input  wire renamePkg::archRegT dispatchArch,
  input  wire renamePkg::physRegT allocPhys,
  input  wire renamePkg::physRegT oldPhys,
  input  wire logic               complete,
  input  wire logic [idxW-1:0]    completeIdx,
  input  wire logic               rollback,
  input  wire logic [idxW-1:0]    rollbackIdx,
  output logic                    bufferReady,
  output logic      [idxW-1:0]    dispatchIdx,
  output logic                    retire,
  output logic                    halt,
  output logic                    recover,
  output renamePkg::archRegT      retireArch,
  output renamePkg::physRegT      retirePhys,
  output renamePkg::physRegT      retireOldPhys
);

  logic            write;
  logic            rollbackTaken;
  logic            draining;
  logic            full;
  logic            empty;
  logic [idxW-1:0] head;
  logic [idxW-1:0] tail;
  logic [idxW-1:0] rollbackNext;
  logic            headValid;
  logic            headComplete;
  logic            headHalt;
  logic            flushTargetValid;

  assign bufferReady = !draining && !full;
  assign write = dispatch && bufferReady;
  assign dispatchIdx = tail;

  // in-order retire, one per cycle
  assign retire = headValid && headComplete;
  assign halt = retire && headHalt;

  // a rollback to an empty slot is ignored
  assign rollbackTaken = rollback && flushTargetValid;
  assign rollbackNext = rollbackIdx + 1'b1;

  ringPointers #(.robDepth(robDepth)) ringPointers_inst (
    .clock      (clock),
    .reset      (reset),
    .advanceHead(retire),
    .advanceTail(write),
    .loadTail   (rollbackTaken),
    .loadValue  (rollbackNext),
    .head       (head),
    .tail       (tail),
    .full       (full),
    .empty      (empty)
  );

  robEntries #(.robDepth(robDepth)) robEntries_inst (
    .clock           (clock),
    .reset           (reset),
    .write           (write),
    .writeIdx        (tail),
    .writeArch       (dispatchArch),
    .writePhys       (allocPhys),
    .writeOldPhys    (oldPhys),
    .writeHalt       (dispatchHalt),
    .markComplete    (complete),
    .completeIdx     (completeIdx),
    .releaseHead     (retire),
    .headIdx         (head),
    .flush           (rollbackTaken),
    .flushIdx        (rollbackIdx),
    .tailIdx         (tail),
    .headValid       (headValid),
    .headComplete    (headComplete),
    .headHalt        (headHalt),
    .headArch        (retireArch),
    .headPhys        (retirePhys),
    .headOldPhys     (retireOldPhys),
    .flushTargetValid(flushTargetValid)
  );

  rollbackControl rollbackControl_inst (
    .clock        (clock),
    .reset        (reset),
    .rollbackTaken(rollbackTaken),
    .bufferEmpty  (empty),
    .draining     (draining),
    .recover      (recover)
  );

endmodule

`default_nettype wire

// File: rename/freeList.sv
`default_nettype none
`timescale 1ns/1ns

module freeList (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               allocate,
  input  wire logic               releaseStrobe,
  input  wire renamePkg::physRegT releasePhys,
  input  wire logic               commit,
  input  wire logic               recover,
  output renamePkg::physRegT      allocPhys,
  output logic                    notEmpty
);

  localparam int ptrW = $clog2(renamePkg::freeDepth);

  // extra top bit tells a full queue from an empty one
  logic [ptrW:0]      specRd;
  logic [ptrW:0]      commitRd;
  logic [ptrW:0]      wrPtr;
  logic [ptrW:0]      count;
  renamePkg::physRegT tags [renamePkg::freeDepth];

  // occupancy follows the speculative read pointer, so a recover
  // recomputes it for free
  assign count = wrPtr - specRd;
  assign notEmpty = (count != '0);
  assign allocPhys = tags[specRd[ptrW-1:0]];

  always_ff @(posedge clock) begin
    if (reset) begin
      specRd <= '0;
      commitRd <= '0;
      wrPtr <= (ptrW + 1)'(renamePkg::freeDepth);
      // tags above the architectural ones start out free
      for (int i = 0; i < renamePkg::freeDepth; i++) begin
        tags[i] <= renamePkg::physRegT'(renamePkg::numArchRegs + i);
      end
    end else begin
      // old tag of a retiring instruction
      if (releaseStrobe) begin
        tags[wrPtr[ptrW-1:0]] <= releasePhys;
        wrPtr <= wrPtr + 1'b1;
      end
      if (commit) begin
        commitRd <= commitRd + 1'b1;
      end
      if (recover) begin
        specRd <= commitRd;
      end else if (allocate) begin
        specRd <= specRd + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rename/mapTable.sv
`default_nettype none
`timescale 1ns/1ns

module mapTable (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               rename,
  input  wire renamePkg::archRegT renameArch,
  input  wire renamePkg::physRegT renamePhys,
  input  wire logic               commit,
  input  wire renamePkg::archRegT commitArch,
  input  wire renamePkg::physRegT commitPhys,
  input  wire logic               recover,
  output renamePkg::physRegT      oldPhys
);

  renamePkg::physRegT specMap   [renamePkg::numArchRegs];
  renamePkg::physRegT commitMap [renamePkg::numArchRegs];

  // read before the dispatch is known to be accepted
  assign oldPhys = specMap[renameArch];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity mapping
      for (int i = 0; i < renamePkg::numArchRegs; i++) begin
        specMap[i] <= renamePkg::physRegT'(i);
      end
    end else if (recover) begin
      // drop every speculative rename
      specMap <= commitMap;
    end else if (rename) begin
      specMap[renameArch] <= renamePhys;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < renamePkg::numArchRegs; i++) begin
        commitMap[i] <= renamePkg::physRegT'(i);
      end
    end else if (commit) begin
      commitMap[commitArch] <= commitPhys;
    end
  end

endmodule

`default_nettype wire

// File: rtl/reorderUnit.sv
`default_nettype none
`timescale 1ns/1ns

module reorderUnit #(
  parameter int robDepth = robPkg::robDepthDefault,
  localparam int idxW = $clog2(robDepth)
) (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               dispatch,
  input  wire logic               dispatchHalt,
  input  wire renamePkg::archRegT dispatchArch,
  input  wire logic               complete,
  input  wire logic [idxW-1:0]    completeIdx,
  input  wire logic               rollback,
  input  wire logic [idxW-1:0]    rollbackIdx,
  output logic                    dispatchReady,
  output logic      [idxW-1:0]    dispatchIdx,
  output renamePkg::physRegT      dispatchPhys,
  output logic                    retire,
  output renamePkg::archRegT      retireArch,
  output renamePkg::physRegT      retirePhys,
  output renamePkg::physRegT      retireOldPhys,
  output logic                    halt
);

  logic               bufferReady;
  logic               notEmpty;
  logic               accept;
  logic               recover;
  renamePkg::physRegT oldPhys;

  assign dispatchReady = bufferReady && notEmpty;

  // no dispatch in a rollback cycle
  assign accept = dispatch && dispatchReady && !rollback;

  reorderBuffer #(.robDepth(robDepth)) reorderBuffer_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatch     (accept),
    .dispatchHalt (dispatchHalt),
    .dispatchArch (dispatchArch),
    .allocPhys    (dispatchPhys),
    .oldPhys      (oldPhys),
    .complete     (complete),
    .completeIdx  (completeIdx),
    .rollback     (rollback),
    .rollbackIdx  (rollbackIdx),
    .bufferReady  (bufferReady),
    .dispatchIdx  (dispatchIdx),
    .retire       (retire),
    .halt         (halt),
    .recover      (recover),
    .retireArch   (retireArch),
    .retirePhys   (retirePhys),
    .retireOldPhys(retireOldPhys)
  );

  // retire frees the old tag and commits the read pointer
  freeList freeList_inst (
    .clock        (clock),
    .reset        (reset),
    .allocate     (accept),
    .releaseStrobe(retire),
    .releasePhys  (retireOldPhys),
    .commit       (retire),
    .recover      (recover),
    .allocPhys    (dispatchPhys),
    .notEmpty     (notEmpty)
  );

  mapTable mapTable_inst (
    .clock     (clock),
    .reset     (reset),
    .rename    (accept),
    .renameArch(dispatchArch),
    .renamePhys(dispatchPhys),
    .commit    (retire),
    .commitArch(retireArch),
    .commitPhys(retirePhys),
    .recover   (recover),
    .oldPhys   (oldPhys)
  );

endmodule

`default_nettype wire

// File: tests/reorderUnitTb.sv
`default_nettype none
`timescale 1ns/1ns

module reorderUnitTb;

  localparam int idxW = $clog2(robPkg::robDepthDefault);
  // the tests take about 200 cycles, so this leaves a wide margin
  localparam int cycleLimit = 3000;
  localparam int waitLimit = 100;

  typedef struct packed {
    logic [idxW-1:0]    idx;
    renamePkg::archRegT arch;
    renamePkg::physRegT phys;
    renamePkg::physRegT oldPhys;
    logic               haltFlag;
  } entryT;

  logic               clock;
  logic               reset;
  logic               dispatch;
  logic               dispatchHalt;
  renamePkg::archRegT dispatchArch;
  logic               complete;
  logic [idxW-1:0]    completeIdx;
  logic               rollback;
  logic [idxW-1:0]    rollbackIdx;
  logic               dispatchReady;
  logic [idxW-1:0]    dispatchIdx;
  renamePkg::physRegT dispatchPhys;
  logic               retire;
  renamePkg::archRegT retireArch;
  renamePkg::physRegT retirePhys;
  renamePkg::physRegT retireOldPhys;
  logic               halt;

  // reference model of the rename state
  renamePkg::physRegT specMap   [renamePkg::numArchRegs];
  renamePkg::physRegT commitMap [renamePkg::numArchRegs];
  renamePkg::physRegT freeQ [$];
  entryT              inflight [$];
  logic               doneFlag [robPkg::robDepthDefault];
  int                 specTaken;
  logic [idxW-1:0]    expTail;
  renamePkg::physRegT lastRetiredPhys;
  int                 retiredCount;
  int                 haltCount;
  int                 errors;
  int                 cycleCount;
  string              testName;

  reorderUnit #(.robDepth(robPkg::robDepthDefault)) reorderUnit_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatch     (dispatch),
    .dispatchHalt (dispatchHalt),
    .dispatchArch (dispatchArch),
    .complete     (complete),
    .completeIdx  (completeIdx),
    .rollback     (rollback),
    .rollbackIdx  (rollbackIdx),
    .dispatchReady(dispatchReady),
    .dispatchIdx  (dispatchIdx),
    .dispatchPhys (dispatchPhys),
    .retire       (retire),
    .retireArch   (retireArch),
    .retirePhys   (retirePhys),
    .retireOldPhys(retireOldPhys),
    .halt         (halt)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("ERROR: run did not finish within %0d cycles", cycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic reportMismatch(input string what, input int expected, input int actual);
    errors++;
    $display("MISMATCH %s: %s expected %0d actual %0d", testName, what, expected, actual);
  endtask

  task automatic reportError(input string msg);
    errors++;
    $display("ERROR %s: %s", testName, msg);
  endtask

  // retirements checked mid-cycle against the oldest in-flight entry
  always @(negedge clock) begin
    entryT e;
    if (!reset) begin
      if (halt) haltCount++;
      if (retire) retiredCount++;
      if (halt && !retire) reportError("halt high without a retire");
      if (retire && inflight.size() == 0) begin
        reportError("retire with no instruction in flight");
      end else if (retire) begin
        e = inflight.pop_front();
        if (!doneFlag[e.idx]) reportError("entry retired before it completed");
        if (retireArch !== e.arch) reportMismatch("retireArch", int'(e.arch), int'(retireArch));
        if (retirePhys !== e.phys) reportMismatch("retirePhys", int'(e.phys), int'(retirePhys));
        if (retireOldPhys !== e.oldPhys) begin
          reportMismatch("retireOldPhys", int'(e.oldPhys), int'(retireOldPhys));
        end
        if (halt !== e.haltFlag) reportMismatch("halt", int'(e.haltFlag), int'(halt));
        commitMap[e.arch] = e.phys;
        void'(freeQ.pop_front());
        freeQ.push_back(e.oldPhys);
        specTaken--;
        lastRetiredPhys = e.phys;
      end
    end
  end

  task automatic tick();
    @(posedge clock);
    #1;
  endtask

  function automatic renamePkg::archRegT randomArch();
    return renamePkg::archRegT'($urandom % renamePkg::numArchRegs);
  endfunction

  task automatic resetDut();
    reset = 1'b1;
    repeat (5) tick();
    reset = 1'b0;
    for (int i = 0; i < renamePkg::numArchRegs; i++) begin
      specMap[i] = renamePkg::physRegT'(i);
      commitMap[i] = renamePkg::physRegT'(i);
    end
    freeQ.delete();
    for (int i = 0; i < renamePkg::freeDepth; i++) begin
      freeQ.push_back(renamePkg::physRegT'(renamePkg::numArchRegs + i));
    end
    for (int i = 0; i < robPkg::robDepthDefault; i++) begin
      doneFlag[i] = 1'b0;
    end
    inflight.delete();
    specTaken = 0;
    expTail = '0;
    #1;
    if (dispatchReady !== 1'b1) reportMismatch("dispatchReady after reset", 1, int'(dispatchReady));
    if (retire !== 1'b0) reportMismatch("retire after reset", 0, int'(retire));
    if (halt !== 1'b0) reportMismatch("halt after reset", 0, int'(halt));
    tick();
  endtask

  task automatic dispatchOne(input renamePkg::archRegT arch, input logic haltFlag);
    entryT e;
    if (dispatchReady !== 1'b1) reportError("dispatchReady low when a dispatch was due");
    dispatch = 1'b1;
    dispatchArch = arch;
    dispatchHalt = haltFlag;
    #1;
    if (dispatchIdx !== expTail) reportMismatch("dispatchIdx", int'(expTail), int'(dispatchIdx));
    if (dispatchPhys !== freeQ[specTaken]) begin
      reportMismatch("dispatchPhys", int'(freeQ[specTaken]), int'(dispatchPhys));
    end
    e.idx = expTail;
    e.arch = arch;
    e.phys = freeQ[specTaken];
    e.oldPhys = specMap[arch];
    e.haltFlag = haltFlag;
    inflight.push_back(e);
    specMap[arch] = e.phys;
    doneFlag[expTail] = 1'b0;
    specTaken++;
    expTail = expTail + 1'b1;
    tick();
    dispatch = 1'b0;
    dispatchHalt = 1'b0;
  endtask

  // the entry may retire from the cycle after the completion edge
  task automatic completeOne(input logic [idxW-1:0] idx);
    complete = 1'b1;
    completeIdx = idx;
    tick();
    complete = 1'b0;
    doneFlag[idx] = 1'b1;
  endtask

  task automatic waitRetired(input int target);
    int waited;
    waited = 0;
    while (retiredCount < target && waited < waitLimit) begin
      tick();
      waited++;
    end
    if (retiredCount < target) reportError("timed out waiting for retirement");
  endtask

  task automatic dispatchTags();
    renamePkg::archRegT regA;
    renamePkg::archRegT regB;
    int base;
    testName = "dispatchTags";
    resetDut();
    base = retiredCount;
    regA = randomArch();
    regB = randomArch();
    // alternating registers so old tags come from earlier renames
    for (int i = 0; i < 6; i++) begin
      if (dispatchIdx !== idxW'(i)) reportMismatch("dispatchIdx count", i, int'(dispatchIdx));
      if (dispatchPhys !== renamePkg::physRegT'(32 + i)) begin
        reportMismatch("dispatchPhys count", 32 + i, int'(dispatchPhys));
      end
      dispatchOne((i % 2 == 0) ? regA : regB, 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      completeOne(idxW'(i));
    end
    waitRetired(base + 6);
  endtask

  task automatic inOrderRetire();
    logic [idxW-1:0] order [6];
    logic [idxW-1:0] swap;
    int base;
    int j;
    testName = "inOrderRetire";
    base = retiredCount;
    for (int i = 0; i < 6; i++) begin
      order[i] = expTail;
      dispatchOne(randomArch(), 1'b0);
    end
    for (int i = 5; i > 0; i--) begin
      j = int'($urandom % (i + 1));
      swap = order[i];
      order[i] = order[j];
      order[j] = swap;
    end
    for (int i = 0; i < 6; i++) begin
      completeOne(order[i]);
    end
    waitRetired(base + 6);
  endtask

  task automatic fullStall();
    int base;
    testName = "fullStall";
    resetDut();
    base = retiredCount;
    repeat (15) dispatchOne(randomArch(), 1'b0);
    if (dispatchReady !== 1'b0) reportMismatch("dispatchReady when full", 0, int'(dispatchReady));
    // strobe while full must be dropped
    dispatch = 1'b1;
    dispatchArch = randomArch();
    tick();
    dispatch = 1'b0;
    if (dispatchIdx !== idxW'(15)) reportMismatch("dispatchIdx after stall", 15, int'(dispatchIdx));
    completeOne('0);
    waitRetired(base + 1);
    if (dispatchIdx !== idxW'(15)) reportMismatch("dispatchIdx after retire", 15, int'(dispatchIdx));
    dispatchOne(randomArch(), 1'b0);
    for (int i = 1; i < 16; i++) begin
      completeOne(idxW'(i));
    end
    waitRetired(base + 16);
  endtask

  task automatic rollbackRecover();
    logic [idxW-1:0]    keepIdx;
    logic [idxW-1:0]    firstIdx;
    logic [idxW-1:0]    newIdx;
    renamePkg::archRegT flushedArch;
    renamePkg::physRegT nextTag;
    int base;
    int waited;
    testName = "rollbackRecover";
    resetDut();
    base = retiredCount;
    repeat (5) dispatchOne(randomArch(), 1'b0);
    firstIdx = inflight[0].idx;
    keepIdx = inflight[1].idx;
    flushedArch = inflight[2].arch;
    rollback = 1'b1;
    rollbackIdx = keepIdx;
    repeat (3) void'(inflight.pop_back());
    expTail = keepIdx + 1'b1;
    tick();
    rollback = 1'b0;
    // late completions of flushed entries, then a dispatch in drain
    for (int i = 1; i < 4; i++) begin
      completeOne(keepIdx + idxW'(i));
    end
    dispatch = 1'b1;
    dispatchArch = randomArch();
    tick();
    dispatch = 1'b0;
    if (dispatchReady !== 1'b0) reportMismatch("dispatchReady in drain", 0, int'(dispatchReady));
    completeOne(keepIdx);
    completeOne(firstIdx);
    waited = 0;
    while (dispatchReady !== 1'b1 && waited < waitLimit) begin
      tick();
      waited++;
    end
    if (dispatchReady !== 1'b1) reportError("dispatch never resumed after rollback");
    if (retiredCount != base + 2) reportMismatch("retired before resume", base + 2, retiredCount);
    // recovery restores the committed view
    for (int i = 0; i < renamePkg::numArchRegs; i++) begin
      specMap[i] = commitMap[i];
    end
    specTaken = 0;
    nextTag = lastRetiredPhys + 1'b1;
    if (dispatchPhys !== nextTag) reportMismatch("dispatchPhys after recover", int'(nextTag),
      int'(dispatchPhys));
    newIdx = expTail;
    dispatchOne(flushedArch, 1'b0);
    completeOne(newIdx);
    waitRetired(base + 3);
    repeat (3) tick();
    if (retiredCount != base + 3) reportMismatch("retire count", base + 3, retiredCount);
  endtask

  task automatic haltRetire();
    logic [idxW-1:0] first;
    int base;
    int haltBase;
    testName = "haltRetire";
    base = retiredCount;
    haltBase = haltCount;
    first = expTail;
    dispatchOne(randomArch(), 1'b0);
    dispatchOne(randomArch(), 1'b1);
    dispatchOne(randomArch(), 1'b0);
    for (int i = 0; i < 3; i++) begin
      completeOne(first + idxW'(i));
    end
    waitRetired(base + 3);
    repeat (2) tick();
    if (haltCount != haltBase + 1) reportMismatch("halt pulses", haltBase + 1, haltCount);
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    dispatch = 1'b0;
    dispatchHalt = 1'b0;
    dispatchArch = '0;
    complete = 1'b0;
    completeIdx = '0;
    rollback = 1'b0;
    rollbackIdx = '0;
    errors = 0;
    retiredCount = 0;
    haltCount = 0;
    cycleCount = 0;
    specTaken = 0;
    expTail = '0;
    lastRetiredPhys = '0;
    testName = "reset";
    void'($urandom(52758));
    dispatchTags();
    inOrderRetire();
    fullStall();
    rollbackRecover();
    haltRetire();
    $display("reorderUnitTb done: %0d errors, %0d retired", errors, retiredCount);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: reorderUnit.f
common/robPkg.sv
common/renamePkg.sv
rtl/ringPointers.sv
rtl/rollbackControl.sv
rob/robEntries.sv
rob/reorderBuffer.sv
rename/freeList.sv
rename/mapTable.sv
rtl/reorderUnit.sv
tests/reorderUnitTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# build the reorder unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module reorderUnitTb \
  -f reorderUnit.f -o simReorderUnit > build.log 2>&1 \
  && ./obj_dir/simReorderUnit > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no result line in log"; exit 1; }
exit 0
